/* vlog.f */
hw/radio_fe_pkg.sv
hw/fe_regmap_pkg.sv
hw/fe_ctrl_regs.sv
hw/fe_sample_path.sv
hw/fe_gpio_atr.sv
hw/radio_fe_top.sv
verification/tb_radio_fe.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_radio_fe
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* verification/tb_radio_fe.sv */
// testbench for radio_fe_top with AXI4-Lite tasks, LFSR, register table and datapath checks
`timescale 1ns/1ps
`default_nettype none

module tb_radio_fe
   import radio_fe_pkg::*, fe_regmap_pkg::*;
();

   localparam int TIMEOUT   = 50;   // cycles per handshake wait
   localparam int N_SAMPLES = 12;

   logic                                radio_clk;
   logic                                i_reset;
   logic [AXI_ADDR_W-1:0]               awaddr;
   logic [AXI_ADDR_W-1:0]               araddr;
   logic                                awvalid;
   logic                                wvalid;
   logic                                bready;
   logic                                arvalid;
   logic                                rready;
   logic [AXI_DATA_W-1:0]               wdata;
   logic [AXI_DATA_W/8-1:0]             wstrb;
   wire                                 awready;
   wire                                 wready;
   wire                                 bvalid;
   wire                                 arready;
   wire                                 rvalid;
   wire  [1:0]                          bresp;
   wire  [1:0]                          rresp;
   wire  [AXI_DATA_W-1:0]               rdata;
   logic [NUM_RADIOS-1:0][SAMPLE_W-1:0] rx_in;
   logic [NUM_RADIOS-1:0][SAMPLE_W-1:0] tx_in;
   logic [NUM_RADIOS-1:0]               rx_stb_in;
   wire  [NUM_RADIOS-1:0][SAMPLE_W-1:0] rx_out;
   wire  [NUM_RADIOS-1:0][SAMPLE_W-1:0] tx_out;
   wire  [NUM_RADIOS-1:0]               rx_stb_out;
   logic [NUM_RADIOS-1:0][GPIO_W-1:0]   gpio_in;
   wire  [NUM_RADIOS-1:0][GPIO_W-1:0]   gpio_out;
   wire  [NUM_RADIOS-1:0][GPIO_W-1:0]   gpio_ddr;
   wire  [NUM_RADIOS-1:0][LED_W-1:0]    led;
   logic [NUM_RADIOS-1:0][MISC_W-1:0]   misc_in;
   wire  [NUM_RADIOS-1:0][MISC_W-1:0]   misc_out;

   logic [31:0] lfsr_state;
   logic [31:0] shadow [NUM_RADIOS][8];   // expected rw register contents
   int          errors, checks, tests_run, tests_failed, test_start_errs;
   string       test_name;

   // register table of offset, radio, write value, read-only flag and write response
   logic [AXI_ADDR_W-1:0] tbl_ofs[$];
   int                    tbl_radio[$];
   logic [31:0]           tbl_wdata[$];
   logic                  tbl_ro[$];
   logic [1:0]            tbl_resp[$];

   radio_fe_top u_dut (
      .radio_clk       (radio_clk),
      .i_reset         (i_reset),
      .i_s_axi_awaddr  (awaddr),
      .i_s_axi_awvalid (awvalid),
      .o_s_axi_awready (awready),
      .i_s_axi_wdata   (wdata),
      .i_s_axi_wstrb   (wstrb),
      .i_s_axi_wvalid  (wvalid),
      .o_s_axi_wready  (wready),
      .o_s_axi_bvalid  (bvalid),
      .o_s_axi_bresp   (bresp),
      .i_s_axi_bready  (bready),
      .i_s_axi_araddr  (araddr),
      .i_s_axi_arvalid (arvalid),
      .o_s_axi_arready (arready),
      .o_s_axi_rvalid  (rvalid),
      .o_s_axi_rdata   (rdata),
      .o_s_axi_rresp   (rresp),
      .i_s_axi_rready  (rready),
      .i_rx            (rx_in),
      .i_rx_stb        (rx_stb_in),
      .o_rx            (rx_out),
      .o_rx_stb        (rx_stb_out),
      .i_tx            (tx_in),
      .o_tx            (tx_out),
      .i_db_gpio_in    (gpio_in),
      .o_db_gpio_out   (gpio_out),
      .o_db_gpio_ddr   (gpio_ddr),
      .o_radio_led     (led),
      .i_misc_in       (misc_in),
      .o_misc_out      (misc_out)
   );

   always #10 radio_clk = ~radio_clk;

   ////////////////////////////////////////////////////////////////////////////
   // random numbers and bookkeeping
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // taps 32,22,2,1
   endfunction

   // one step per bit taken
   function automatic logic [31:0] next_rand32();
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_state = galois_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [AXI_ADDR_W-1:0] reg_addr(input int r, input logic [7:0] ofs);
      return AXI_ADDR_W'(r * RADIO_STRIDE) + ofs;
   endfunction

   task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name       = name;
      test_start_errs = errors;
      tests_run++;
   endtask

   task automatic end_test();
      if (errors == test_start_errs) begin
         $display("test %s: passed", test_name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", test_name, errors - test_start_errs);
      end
   endtask

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      $display("SOME TESTS FAILED");
      $finish;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // AXI4-Lite access with inputs changed on the falling edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      int cnt;
      @(negedge radio_clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      cnt     = 0;
      do begin
         @(negedge radio_clk);
         cnt++;
      end while (!bvalid && cnt < TIMEOUT);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      resp    = bresp;
      if (!bvalid) abort_run($sformatf("no write response for address %h", addr));
   endtask

   task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int cnt;
      @(negedge radio_clk);
      araddr  = addr;
      arvalid = 1'b1;
      cnt     = 0;
      do begin
         @(negedge radio_clk);
         cnt++;
      end while (!rvalid && cnt < TIMEOUT);
      arvalid = 1'b0;
      data    = rdata;
      resp    = rresp;
      if (!rvalid) abort_run($sformatf("no read data for address %h", addr));
   endtask

   task automatic write_reg(input int r, input logic [7:0] ofs, input logic [31:0] val);
      logic [1:0] resp;
      axi_write(reg_addr(r, ofs), val, resp);
      expect_eq($sformatf("bresp at %h", reg_addr(r, ofs)), 32'(RESP_OKAY), 32'(resp));
      shadow[r][int'(ofs) / 4] = val;
   endtask

   task automatic add_entry(input logic [7:0] ofs, input int r, input logic ro,
                            input logic [1:0] resp);
      tbl_ofs.push_back(ofs);
      tbl_radio.push_back(r);
      tbl_wdata.push_back(next_rand32());
      tbl_ro.push_back(ro);
      tbl_resp.push_back(resp);
   endtask

   task automatic apply_entry(input int i);
      logic [AXI_ADDR_W-1:0] addr;
      logic [31:0]           data;
      logic [1:0]            resp;
      int                    r;
      r    = tbl_radio[i];
      addr = reg_addr(r, tbl_ofs[i]);
      axi_write(addr, tbl_wdata[i], resp);
      expect_eq($sformatf("bresp at %h", addr), 32'(tbl_resp[i]), 32'(resp));
      if (tbl_resp[i] == RESP_OKAY) shadow[r][int'(tbl_ofs[i]) / 4] = tbl_wdata[i];
      axi_read(addr, data, resp);
      if (tbl_resp[i] == RESP_OKAY) begin
         expect_eq($sformatf("rdata at %h", addr), tbl_wdata[i], data);
         expect_eq($sformatf("rresp at %h", addr), 32'(RESP_OKAY), 32'(resp));
      end else if (tbl_ro[i]) begin
         // read-only word still shows the input it mirrors
         expect_eq($sformatf("rdata at %h", addr),
                   (tbl_ofs[i] == REG_GPIO_IN) ? gpio_in[r] : misc_in[r], data);
         expect_eq($sformatf("rresp at %h", addr), 32'(RESP_OKAY), 32'(resp));
      end else begin
         expect_eq($sformatf("rdata at %h", addr), 32'h0, data);
         expect_eq($sformatf("rresp at %h", addr), 32'(RESP_SLVERR), 32'(resp));
      end
   endtask

   task automatic sweep_shadow();
      logic [31:0] data;
      logic [1:0]  resp;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         for (int k = 0; k < 7; k++) begin
            axi_read(reg_addr(r, 8'(4 * k)), data, resp);
            expect_eq($sformatf("rdata at %h", reg_addr(r, 8'(4 * k))), shadow[r][k], data);
            expect_eq($sformatf("rresp at %h", reg_addr(r, 8'(4 * k))),
                      32'(RESP_OKAY), 32'(resp));
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] v, exp_rx, exp_tx, exp_gpio, data;
      logic [1:0]  resp;
      logic [2:0]  exp_led;
      logic        exp_stb;
      radio_clk  = 1'b0;
      i_reset    = 1'b1;
      lfsr_state = 32'hc079;
      awaddr     = '0;
      araddr     = '0;
      awvalid    = 1'b0;
      wvalid     = 1'b0;
      arvalid    = 1'b0;
      bready     = 1'b1;   // responses taken as soon as they show
      rready     = 1'b1;
      wdata      = '0;
      wstrb      = '1;
      rx_in      = '0;
      tx_in      = '0;
      rx_stb_in  = '0;
      gpio_in    = '0;
      misc_in    = '0;
      errors     = 0;
      checks     = 0;
      tests_run  = 0;
      tests_failed = 0;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         for (int k = 0; k < 8; k++) shadow[r][k] = '0;
      end
      repeat (3) @(negedge radio_clk);
      i_reset = 1'b0;

      begin_test("reset state");
      @(negedge radio_clk);
      expect_eq("o_s_axi_awready", 32'h0, 32'(awready));
      expect_eq("o_s_axi_wready", 32'h0, 32'(wready));
      expect_eq("o_s_axi_arready", 32'h0, 32'(arready));
      expect_eq("o_s_axi_bvalid", 32'h0, 32'(bvalid));
      expect_eq("o_s_axi_rvalid", 32'h0, 32'(rvalid));
      for (int r = 0; r < NUM_RADIOS; r++) begin
         expect_eq($sformatf("o_db_gpio_out[%0d]", r), 32'h0, gpio_out[r]);
         expect_eq($sformatf("o_db_gpio_ddr[%0d]", r), 32'h0, gpio_ddr[r]);
         expect_eq($sformatf("o_radio_led[%0d]", r), 32'h0, 32'(led[r]));
         expect_eq($sformatf("o_misc_out[%0d]", r), 32'h0, misc_out[r]);
         expect_eq($sformatf("o_rx[%0d]", r), 32'h0, rx_out[r]);
         expect_eq($sformatf("o_rx_stb[%0d]", r), 32'h0, 32'(rx_stb_out[r]));
         expect_eq($sformatf("o_tx[%0d]", r), 32'h0, tx_out[r]);
      end
      end_test();

      // inputs that the read-only registers mirror
      for (int r = 0; r < NUM_RADIOS; r++) begin
         gpio_in[r] = next_rand32();
         misc_in[r] = next_rand32();
      end
      for (int r = 0; r < NUM_RADIOS; r++) begin
         for (int k = 0; k < 7; k++) add_entry(8'(4 * k), r, 1'b0, RESP_OKAY);
      end
      add_entry(REG_GPIO_IN, 0, 1'b1, RESP_SLVERR);
      add_entry(REG_MISC_IN, 1, 1'b1, RESP_SLVERR);
      add_entry(8'h3C, 0, 1'b0, RESP_SLVERR);
      add_entry(8'h24, 1, 1'b0, RESP_SLVERR);
      add_entry(8'h00, 2, 1'b0, RESP_SLVERR);   // no third radio

      begin_test("register readback");
      foreach (tbl_ofs[i]) if (tbl_resp[i] == RESP_OKAY) apply_entry(i);
      sweep_shadow();
      end_test();

      begin_test("error responses");
      foreach (tbl_ofs[i]) if (tbl_resp[i] != RESP_OKAY) apply_entry(i);
      sweep_shadow();
      end_test();

      begin_test("atr and leds");
      for (int r = 0; r < NUM_RADIOS; r++) begin
         for (int k = 1; k < 6; k++) write_reg(r, 8'(4 * k), next_rand32());
         for (int s = 0; s < 4; s++) begin
            write_reg(r, REG_CTRL, 32'(s) << CTRL_RX_RUN);
            @(negedge radio_clk);   // register, then output flop
            case (s)
               0:       exp_gpio = shadow[r][int'(REG_ATR_IDLE) / 4];
               1:       exp_gpio = shadow[r][int'(REG_ATR_RX) / 4];
               2:       exp_gpio = shadow[r][int'(REG_ATR_TX) / 4];
               default: exp_gpio = shadow[r][int'(REG_ATR_FDX) / 4];
            endcase
            // idle dark, rx alone bit 0, tx bit 1, full duplex bits 2 and 1
            exp_led = (s == 0) ? 3'b000 : (s == 1) ? 3'b001 : (s == 2) ? 3'b010 : 3'b110;
            expect_eq($sformatf("o_db_gpio_out[%0d]", r), exp_gpio, gpio_out[r]);
            expect_eq($sformatf("o_db_gpio_ddr[%0d]", r), shadow[r][int'(REG_DDR) / 4],
                      gpio_ddr[r]);
            expect_eq($sformatf("o_radio_led[%0d]", r), 32'(exp_led), 32'(led[r]));
         end
      end
      end_test();

      begin_test("sample paths");
      for (int r = 0; r < NUM_RADIOS; r++) begin
         for (int swap = 0; swap < 4; swap++) begin
            // bit 0 swaps rx, bit 1 swaps tx
            write_reg(r, REG_CTRL,
                      (32'(swap[0]) << CTRL_RX_SWAP) | (32'(swap[1]) << CTRL_TX_SWAP));
            exp_rx  = '0;
            exp_tx  = '0;
            exp_stb = 1'b0;
            for (int k = 0; k <= N_SAMPLES; k++) begin
               @(negedge radio_clk);
               if (k > 0) begin
                  expect_eq($sformatf("o_rx[%0d]", r), exp_rx, rx_out[r]);
                  expect_eq($sformatf("o_rx_stb[%0d]", r), 32'(exp_stb), 32'(rx_stb_out[r]));
                  expect_eq($sformatf("o_tx[%0d]", r), exp_tx, tx_out[r]);
               end
               if (k < N_SAMPLES) begin
                  rx_in[r]     = next_rand32();
                  tx_in[r]     = next_rand32();
                  rx_stb_in[r] = k[0];
                  exp_stb      = k[0];
                  // swap puts Q on top and I below
                  exp_rx = swap[0] ? {rx_in[r][15:0], rx_in[r][31:16]} : rx_in[r];
                  exp_tx = swap[1] ? {tx_in[r][15:0], tx_in[r][31:16]} : tx_in[r];
               end
            end
            rx_stb_in[r] = 1'b0;
         end
      end
      end_test();

      begin_test("misc and gpio inputs");
      for (int r = 0; r < NUM_RADIOS; r++) begin
         v = next_rand32();
         write_reg(r, REG_MISC_OUT, v);
         expect_eq($sformatf("o_misc_out[%0d]", r), v, misc_out[r]);
         gpio_in[r] = next_rand32();
         @(negedge radio_clk);   // read goes out 2 cycles after the pins change
         axi_read(reg_addr(r, REG_GPIO_IN), data, resp);
         expect_eq($sformatf("rdata at %h", reg_addr(r, REG_GPIO_IN)), gpio_in[r], data);
         misc_in[r] = next_rand32();   // read goes out 1 cycle later
         axi_read(reg_addr(r, REG_MISC_IN), data, resp);
         expect_eq($sformatf("rdata at %h", reg_addr(r, REG_MISC_IN)), misc_in[r], data);
      end
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/radio_fe_top.sv */
// top level, control registers plus per-radio sample path and gpio blocks
`timescale 1ns/1ps
`default_nettype none

module radio_fe_top
   import radio_fe_pkg::*, fe_regmap_pkg::*;
(
   input  wire                                  radio_clk,
   input  wire                                  i_reset,
   // AXI4-Lite slave
   input  wire  [AXI_ADDR_W-1:0]                i_s_axi_awaddr,
   input  wire                                  i_s_axi_awvalid,
   output logic                                 o_s_axi_awready,
   input  wire  [AXI_DATA_W-1:0]                i_s_axi_wdata,
   input  wire  [AXI_DATA_W/8-1:0]              i_s_axi_wstrb,
   input  wire                                  i_s_axi_wvalid,
   output logic                                 o_s_axi_wready,
   output logic                                 o_s_axi_bvalid,
   output logic [1:0]                           o_s_axi_bresp,
   input  wire                                  i_s_axi_bready,
   input  wire  [AXI_ADDR_W-1:0]                i_s_axi_araddr,
   input  wire                                  i_s_axi_arvalid,
   output logic                                 o_s_axi_arready,
   output logic                                 o_s_axi_rvalid,
   output logic [AXI_DATA_W-1:0]                o_s_axi_rdata,
   output logic [1:0]                           o_s_axi_rresp,
   input  wire                                  i_s_axi_rready,
   // per radio
   input  wire sample_u [NUM_RADIOS-1:0]        i_rx,
   input  wire  [NUM_RADIOS-1:0]                i_rx_stb,
   output sample_u      [NUM_RADIOS-1:0]        o_rx,
   output logic [NUM_RADIOS-1:0]                o_rx_stb,
   input  wire sample_u [NUM_RADIOS-1:0]        i_tx,
   output sample_u      [NUM_RADIOS-1:0]        o_tx,
   input  wire  [NUM_RADIOS-1:0][GPIO_W-1:0]    i_db_gpio_in,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_db_gpio_out,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_db_gpio_ddr,
   output logic [NUM_RADIOS-1:0][LED_W-1:0]     o_radio_led,
   input  wire  [NUM_RADIOS-1:0][MISC_W-1:0]    i_misc_in,
   output logic [NUM_RADIOS-1:0][MISC_W-1:0]    o_misc_out
);

   logic [NUM_RADIOS-1:0]             rx_swap, tx_swap, rx_run, tx_run;
   logic [NUM_RADIOS-1:0][GPIO_W-1:0] atr_idle, atr_rx, atr_tx, atr_fdx, ddr;
   logic [NUM_RADIOS-1:0][GPIO_W-1:0] gpio_in_sync;

   fe_ctrl_regs u_ctrl_regs (
      .radio_clk       (radio_clk),
      .i_reset         (i_reset),
      .i_s_axi_awaddr  (i_s_axi_awaddr),
      .i_s_axi_awvalid (i_s_axi_awvalid),
      .o_s_axi_awready (o_s_axi_awready),
      .i_s_axi_wdata   (i_s_axi_wdata),
      .i_s_axi_wstrb   (i_s_axi_wstrb),
      .i_s_axi_wvalid  (i_s_axi_wvalid),
      .o_s_axi_wready  (o_s_axi_wready),
      .o_s_axi_bvalid  (o_s_axi_bvalid),
      .o_s_axi_bresp   (o_s_axi_bresp),
      .i_s_axi_bready  (i_s_axi_bready),
      .i_s_axi_araddr  (i_s_axi_araddr),
      .i_s_axi_arvalid (i_s_axi_arvalid),
      .o_s_axi_arready (o_s_axi_arready),
      .o_s_axi_rvalid  (o_s_axi_rvalid),
      .o_s_axi_rdata   (o_s_axi_rdata),
      .o_s_axi_rresp   (o_s_axi_rresp),
      .i_s_axi_rready  (i_s_axi_rready),
      .i_misc_in       (i_misc_in),
      .i_gpio_in_sync  (gpio_in_sync),
      .o_rx_swap       (rx_swap),
      .o_tx_swap       (tx_swap),
      .o_rx_run        (rx_run),
      .o_tx_run        (tx_run),
      .o_atr_idle      (atr_idle),
      .o_atr_rx        (atr_rx),
      .o_atr_tx        (atr_tx),
      .o_atr_fdx       (atr_fdx),
      .o_ddr           (ddr),
      .o_misc_out      (o_misc_out)
   );

   ////////////////////////////////////////////////////////////////////////////
   // per-radio datapath
   ////////////////////////////////////////////////////////////////////////////

   for (genvar r = 0; r < NUM_RADIOS; r++) begin : g_radio
      fe_sample_path u_sample_path (
         .radio_clk (radio_clk),
         .i_reset   (i_reset),
         .i_rx_swap (rx_swap[r]),
         .i_tx_swap (tx_swap[r]),
         .i_rx      (i_rx[r]),
         .i_rx_stb  (i_rx_stb[r]),
         .o_rx      (o_rx[r]),
         .o_rx_stb  (o_rx_stb[r]),
         .i_tx      (i_tx[r]),
         .o_tx      (o_tx[r])
      );

      fe_gpio_atr u_gpio_atr (
         .radio_clk      (radio_clk),
         .i_reset        (i_reset),
         .i_rx_run       (rx_run[r]),
         .i_tx_run       (tx_run[r]),
         .i_atr_idle     (atr_idle[r]),
         .i_atr_rx       (atr_rx[r]),
         .i_atr_tx       (atr_tx[r]),
         .i_atr_fdx      (atr_fdx[r]),
         .i_ddr          (ddr[r]),
         .i_db_gpio_in   (i_db_gpio_in[r]),
         .o_db_gpio_out  (o_db_gpio_out[r]),
         .o_db_gpio_ddr  (o_db_gpio_ddr[r]),
         .o_gpio_in_sync (gpio_in_sync[r]),
         .o_led          (o_radio_led[r])
      );
   end

endmodule

`default_nettype wire

/* hw/fe_gpio_atr.sv */
// ATR output select, ddr drive, gpio input synchronizer and status LEDs
`timescale 1ns/1ps
`default_nettype none

module fe_gpio_atr
   import radio_fe_pkg::*;
(
   input  wire               radio_clk,
   input  wire               i_reset,
   // run state
   input  wire               i_rx_run,
   input  wire               i_tx_run,
   // ATR words, one per run state
   input  wire  [GPIO_W-1:0] i_atr_idle,
   input  wire  [GPIO_W-1:0] i_atr_rx,
   input  wire  [GPIO_W-1:0] i_atr_tx,
   input  wire  [GPIO_W-1:0] i_atr_fdx,
   input  wire  [GPIO_W-1:0] i_ddr,
   // daughterboard pins
   input  wire  [GPIO_W-1:0] i_db_gpio_in,
   output logic [GPIO_W-1:0] o_db_gpio_out,
   output logic [GPIO_W-1:0] o_db_gpio_ddr,
   output logic [GPIO_W-1:0] o_gpio_in_sync,
   output logic [LED_W-1:0]  o_led
);

   logic [GPIO_W-1:0] atr_sel;
   logic [LED_W-1:0]  led_next;
   logic [GPIO_W-1:0] gpio_in_meta;

   always_comb begin
      case ({i_tx_run, i_rx_run})
         2'b00:   atr_sel = i_atr_idle;
         2'b01:   atr_sel = i_atr_rx;
         2'b10:   atr_sel = i_atr_tx;
         default: atr_sel = i_atr_fdx;   // full duplex
      endcase
   end

   // {both running, tx, rx alone}
   assign led_next = {i_rx_run & i_tx_run, i_tx_run, i_rx_run & ~i_tx_run};

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;
         o_led         <= '0;
      end else begin
         o_db_gpio_out <= atr_sel;
         o_db_gpio_ddr <= i_ddr;
         o_led         <= led_next;
      end
   end

   // two-flop sync, pins are not radio_clk timed
   always_ff @(posedge radio_clk) begin
      gpio_in_meta   <= i_db_gpio_in;
      o_gpio_in_sync <= gpio_in_meta;
   end

endmodule

`default_nettype wire

/* hw/fe_sample_path.sv */
// registered adc and dac sample path with per-direction I/Q swap
`timescale 1ns/1ps
`default_nettype none

module fe_sample_path
   import radio_fe_pkg::*;
(
   input  wire          radio_clk,
   input  wire          i_reset,
   input  wire          i_rx_swap,
   input  wire          i_tx_swap,
   // adc side
   input  wire sample_u i_rx,
   input  wire          i_rx_stb,
   output sample_u      o_rx,
   output logic         o_rx_stb,
   // dac side, runs every cycle
   input  wire sample_u i_tx,
   output sample_u      o_tx
);

   // exchange I and Q through the array view
   function automatic sample_u swap_iq(input sample_u s, input logic swap);
      sample_u res;
      res.raw = s.raw;
      if (swap) begin
         res.iq[1] = s.iq[0];
         res.iq[0] = s.iq[1];
      end
      return res;
   endfunction

   // one flop stage, a new sample may enter every cycle
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rx     <= '0;
         o_rx_stb <= 1'b0;
         o_tx     <= '0;
      end else begin
         o_rx     <= swap_iq(i_rx, i_rx_swap);
         o_rx_stb <= i_rx_stb;   // strobe rides along with its word
         o_tx     <= swap_iq(i_tx, i_tx_swap);
      end
   end

endmodule

`default_nettype wire

/* hw/fe_ctrl_regs.sv */
// AXI4-Lite slave, per-radio register file, misc input capture, readback mux
`timescale 1ns/1ps
`default_nettype none

module fe_ctrl_regs
   import radio_fe_pkg::*, fe_regmap_pkg::*;
(
   input  wire                                  radio_clk,
   input  wire                                  i_reset,
   // AXI4-Lite slave
   input  wire  [AXI_ADDR_W-1:0]                i_s_axi_awaddr,
   input  wire                                  i_s_axi_awvalid,
   output logic                                 o_s_axi_awready,
   input  wire  [AXI_DATA_W-1:0]                i_s_axi_wdata,
   input  wire  [AXI_DATA_W/8-1:0]              i_s_axi_wstrb,   // full-word writes only
   input  wire                                  i_s_axi_wvalid,
   output logic                                 o_s_axi_wready,
   output logic                                 o_s_axi_bvalid,
   output logic [1:0]                           o_s_axi_bresp,
   input  wire                                  i_s_axi_bready,
   input  wire  [AXI_ADDR_W-1:0]                i_s_axi_araddr,
   input  wire                                  i_s_axi_arvalid,
   output logic                                 o_s_axi_arready,
   output logic                                 o_s_axi_rvalid,
   output logic [AXI_DATA_W-1:0]                o_s_axi_rdata,
   output logic [1:0]                           o_s_axi_rresp,
   input  wire                                  i_s_axi_rready,
   // readback from the radios
   input  wire  [NUM_RADIOS-1:0][MISC_W-1:0]    i_misc_in,
   input  wire  [NUM_RADIOS-1:0][GPIO_W-1:0]    i_gpio_in_sync,
   // per-radio controls
   output logic [NUM_RADIOS-1:0]                o_rx_swap,
   output logic [NUM_RADIOS-1:0]                o_tx_swap,
   output logic [NUM_RADIOS-1:0]                o_rx_run,
   output logic [NUM_RADIOS-1:0]                o_tx_run,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_atr_idle,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_atr_rx,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_atr_tx,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_atr_fdx,
   output logic [NUM_RADIOS-1:0][GPIO_W-1:0]    o_ddr,
   output logic [NUM_RADIOS-1:0][MISC_W-1:0]    o_misc_out
);

   localparam int OFS_W = $clog2(RADIO_STRIDE);

   logic [NUM_RADIOS-1:0][AXI_DATA_W-1:0] ctrl_q;
   logic [NUM_RADIOS-1:0][MISC_W-1:0]     misc_in_q;

   logic                  wr_fire, wr_ok;
   logic                  rd_fire, rd_ok;
   logic [AXI_ADDR_W-1:0] wr_radio, wr_ofs;
   logic [AXI_ADDR_W-1:0] rd_radio, rd_ofs;
   logic [AXI_DATA_W-1:0] rd_data;

   ////////////////////////////////////////////////////////////////////////////
   // handshakes and address split
   ////////////////////////////////////////////////////////////////////////////

   // one write and one read in flight at most
   assign wr_fire = i_s_axi_awvalid & i_s_axi_wvalid & ~o_s_axi_bvalid;
   assign rd_fire = i_s_axi_arvalid & ~o_s_axi_rvalid;

   assign o_s_axi_awready = wr_fire;
   assign o_s_axi_wready  = wr_fire;
   assign o_s_axi_arready = rd_fire;

   assign wr_radio = i_s_axi_awaddr >> OFS_W;
   assign wr_ofs   = i_s_axi_awaddr & AXI_ADDR_W'(RADIO_STRIDE - 1);
   assign rd_radio = i_s_axi_araddr >> OFS_W;
   assign rd_ofs   = i_s_axi_araddr & AXI_ADDR_W'(RADIO_STRIDE - 1);

   // writable offsets only, read-only ones fall to slverr
   always_comb begin
      wr_ok = 1'b0;
      if (wr_radio < AXI_ADDR_W'(NUM_RADIOS)) begin
         case (wr_ofs)
            REG_CTRL, REG_ATR_IDLE, REG_ATR_RX, REG_ATR_TX,
            REG_ATR_FDX, REG_DDR, REG_MISC_OUT: wr_ok = 1'b1;
            default:                            wr_ok = 1'b0;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // register file
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         ctrl_q     <= '0;
         o_atr_idle <= '0;
         o_atr_rx   <= '0;
         o_atr_tx   <= '0;
         o_atr_fdx  <= '0;
         o_ddr      <= '0;
         o_misc_out <= '0;
      end else if (wr_fire && wr_ok) begin
         for (int r = 0; r < NUM_RADIOS; r++) begin
            if (wr_radio == AXI_ADDR_W'(r)) begin
               case (wr_ofs)
                  REG_CTRL:     ctrl_q[r]     <= i_s_axi_wdata;
                  REG_ATR_IDLE: o_atr_idle[r] <= i_s_axi_wdata;
                  REG_ATR_RX:   o_atr_rx[r]   <= i_s_axi_wdata;
                  REG_ATR_TX:   o_atr_tx[r]   <= i_s_axi_wdata;
                  REG_ATR_FDX:  o_atr_fdx[r]  <= i_s_axi_wdata;
                  REG_DDR:      o_ddr[r]      <= i_s_axi_wdata;
                  REG_MISC_OUT: o_misc_out[r] <= i_s_axi_wdata;
                  default: ;
               endcase
            end
         end
      end
   end

   always_comb begin
      for (int r = 0; r < NUM_RADIOS; r++) begin
         o_rx_swap[r] = ctrl_q[r][CTRL_RX_SWAP];
         o_tx_swap[r] = ctrl_q[r][CTRL_TX_SWAP];
         o_rx_run[r]  = ctrl_q[r][CTRL_RX_RUN];
         o_tx_run[r]  = ctrl_q[r][CTRL_TX_RUN];
      end
   end

   // misc inputs land in a flop before readback
   always_ff @(posedge radio_clk) begin
      misc_in_q <= i_misc_in;
   end

   ////////////////////////////////////////////////////////////////////////////
   // readback and responses
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      rd_data = '0;
      rd_ok   = 1'b0;
      for (int r = 0; r < NUM_RADIOS; r++) begin
         if (rd_radio == AXI_ADDR_W'(r)) begin
            rd_ok = 1'b1;
            case (rd_ofs)
               REG_CTRL:     rd_data = ctrl_q[r];
               REG_ATR_IDLE: rd_data = o_atr_idle[r];
               REG_ATR_RX:   rd_data = o_atr_rx[r];
               REG_ATR_TX:   rd_data = o_atr_tx[r];
               REG_ATR_FDX:  rd_data = o_atr_fdx[r];
               REG_DDR:      rd_data = o_ddr[r];
               REG_MISC_OUT: rd_data = o_misc_out[r];
               REG_GPIO_IN:  rd_data = i_gpio_in_sync[r];
               REG_MISC_IN:  rd_data = misc_in_q[r];
               default:      rd_ok   = 1'b0;   // hole in the map, data stays zero
            endcase
         end
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_s_axi_bvalid <= 1'b0;
         o_s_axi_rvalid <= 1'b0;
      end else begin
         if (wr_fire)
            o_s_axi_bvalid <= 1'b1;
         else if (i_s_axi_bready)
            o_s_axi_bvalid <= 1'b0;
         if (rd_fire)
            o_s_axi_rvalid <= 1'b1;
         else if (i_s_axi_rready)
            o_s_axi_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (wr_fire) begin
         o_s_axi_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_fire) begin
         o_s_axi_rdata <= rd_data;
         o_s_axi_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end
   end

endmodule

`default_nettype wire

/* hw/fe_regmap_pkg.sv */
// AXI4-Lite widths, per-radio register offsets, ctrl bits, response codes
`default_nettype none

package fe_regmap_pkg;

   localparam int AXI_ADDR_W   = 8;
   localparam int AXI_DATA_W   = 32;
   localparam int RADIO_STRIDE = 'h40;   // radio r starts at r * stride

   localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 8'h00;
   localparam logic [AXI_ADDR_W-1:0] REG_ATR_IDLE = 8'h04;
   localparam logic [AXI_ADDR_W-1:0] REG_ATR_RX   = 8'h08;
   localparam logic [AXI_ADDR_W-1:0] REG_ATR_TX   = 8'h0C;
   localparam logic [AXI_ADDR_W-1:0] REG_ATR_FDX  = 8'h10;
   localparam logic [AXI_ADDR_W-1:0] REG_DDR      = 8'h14;
   localparam logic [AXI_ADDR_W-1:0] REG_MISC_OUT = 8'h18;
   localparam logic [AXI_ADDR_W-1:0] REG_GPIO_IN  = 8'h1C;   // read only
   localparam logic [AXI_ADDR_W-1:0] REG_MISC_IN  = 8'h20;   // read only

   // bit positions in REG_CTRL
   localparam int CTRL_RX_SWAP = 0;
   localparam int CTRL_TX_SWAP = 1;
   localparam int CTRL_RX_RUN  = 2;
   localparam int CTRL_TX_RUN  = 3;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/radio_fe_pkg.sv */
// radio count, sample and gpio widths, I/Q sample union
`default_nettype none

package radio_fe_pkg;

   localparam int NUM_RADIOS = 2;

   // sample words
   localparam int SAMPLE_W = 32;
   localparam int IQ_W     = 16;

   // daughterboard and misc io
   localparam int GPIO_W = 32;
   localparam int MISC_W = 32;
   localparam int LED_W  = 3;

   // one adc or dac word, seen raw or as an i/q pair
   // iq[1] is I in the upper half, iq[0] is Q
   typedef union packed {
      logic [SAMPLE_W-1:0]  raw;
      logic [1:0][IQ_W-1:0] iq;
   } sample_u;

endpackage

`default_nettype wire
